// File: filelist.f
+incdir+rtl
rtl/vic_load_pkg.sv
rtl/image_loader.sv
rtl/tape_buffer.sv
rtl/vic_loader_top.sv
dv/tb_vic_loader.sv

// File: run.sh
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_vic_loader -f filelist.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -qx "NO ERRORS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: dv/tb_vic_loader.sv
//////////////////////////////
// Loader testbench
// Program, kernal, cartridge and tape downloads into
// the loader top level, with a tape memory model and
// a player FIFO model
//////////////////////////////

`timescale 1ns/1ps

`include "vic_load_cfg.svh"

module tb_vic_loader import vic_load_pkg::*; ();

	localparam int TIMEOUT = 6000;
	localparam int TAP_LEN = 24;
	localparam logic [15:0] PTR_ADDR [8] = '{`VIC_PTR_ADDR_0, `VIC_PTR_ADDR_1,
		`VIC_PTR_ADDR_2, `VIC_PTR_ADDR_3, `VIC_PTR_ADDR_4, `VIC_PTR_ADDR_5,
		`VIC_PTR_ADDR_6, `VIC_PTR_ADDR_7};
	localparam logic [24:0] ROM_OFS [8] = '{25'h0000000, 25'h0003FFF, 25'h0004000,
		25'h0004001, 25'h0005A5A, 25'h0007FFF, 25'h0008000, 25'h0014000};

	// Expected machine memory write, stamped with its cycle
	typedef struct packed {
		logic [31:0] cyc;
		logic [15:0] addr;
		logic [7:0]  data;
	} exp_wr_t;

	logic        clk_sys = 1'b0;
	logic        reset;
	host_xfer_t  host;
	exp_cfg_t    exp_cfg;
	logic        tape_unload;
	logic        autoplay_en;
	logic        host_wait;
	mem_wr_t     mem_wr;
	logic [4:0]  ram_ext;
	logic [4:0]  ram_ext_ro;
	logic [24:0] tmem_addr;
	logic [7:0]  tmem_din;
	logic        tmem_wr;
	logic        tmem_rd;
	logic [7:0]  tmem_dout;
	logic        tmem_ready;
	logic [7:0]  fifo_data;
	logic        fifo_wr;
	logic        fifo_full;
	logic [1:0]  tape_version;
	logic        tape_loaded;
	logic        tape_autoplay;

	int          errors = 0;
	int          cycles = 0;
	exp_wr_t     exp_q[$];
	exp_wr_t     got;
	logic [7:0]  tape_mem [0:255];
	logic [7:0]  tape_ref [0:TAP_LEN-1];
	logic [7:0]  rd_data;
	int          mem_delay = 0;
	int          fifo_cnt = 0;
	int          autoplay_cnt = 0;
	int          autoplay_cyc = 0;
	int          reads_open = 0;
	logic        full_hold = 1'b0;

	vic_loader_top vic_loader_top_inst (
		.clk_sys_i (clk_sys), .reset_i (reset), .host_i (host), .exp_cfg_i (exp_cfg),
		.tape_unload_i (tape_unload), .tape_autoplay_en_i (autoplay_en),
		.host_wait_o (host_wait), .mem_wr_o (mem_wr), .ram_ext_o (ram_ext),
		.ram_ext_ro_o (ram_ext_ro), .tmem_addr_o (tmem_addr), .tmem_din_o (tmem_din),
		.tmem_wr_o (tmem_wr), .tmem_rd_o (tmem_rd), .tmem_dout_i (tmem_dout),
		.tmem_ready_i (tmem_ready), .fifo_data_o (fifo_data), .fifo_wr_o (fifo_wr),
		.fifo_full_i (fifo_full), .tape_version_o (tape_version),
		.tape_loaded_o (tape_loaded), .tape_autoplay_o (tape_autoplay)
	);

	always #20 clk_sys = ~clk_sys;

	// Expansion vector as the switches describe it
	function automatic logic [4:0] ram_vec(input exp_cfg_t c);
		logic [2:0] ext2;
		ext2 = 3'b111 >> (2'd3 - c.ext2_sel);
		ram_vec = {c.ext3_en, ext2, c.ext1_en};
	endfunction

	function automatic logic [7:0] fill_byte(input int a);
		fill_byte = a[7:0] ^ 8'hC3;
	endfunction

	task automatic check(input logic ok, input string msg);
		assert (ok) else begin
			errors++;
			$display("error %0t: %s", $time, msg);
		end
	endtask

	task automatic step();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic expect_wr(input int cyc, input logic [15:0] a, input logic [7:0] d);
		exp_wr_t e;
		e.cyc = 32'(cyc);
		e.addr = a;
		e.data = d;
		exp_q.push_back(e);
	endtask

	task automatic host_send(input logic [24:0] a, input logic [7:0] d, input logic wr_due,
			input logic [15:0] wa);
		step();
		host.wr = 1'b1;
		host.addr = a;
		host.data = d;
		if (wr_due)
			expect_wr(cycles + 1, wa, d);
		step();
		host.wr = 1'b0;
	endtask

	// Host holds the next byte until wait drops
	task automatic tape_send(input int a, input logic [7:0] d);
		step();
		host.wr = 1'b1;
		host.addr = 25'(a);
		host.data = d;
		step();
		host.wr = 1'b0;
		while (host_wait)
			step();
	endtask

	task automatic start_load(input logic [7:0] idx, input logic [7:0] ext);
		step();
		host.index = idx;
		host.file_ext = {24'h0, ext};
		host.download = 1'b1;
		step();
	endtask

	task automatic end_load();
		step();
		host.download = 1'b0;
	endtask

	task automatic load_prg(input logic [15:0] start, input int n);
		logic [15:0] run;
		logic [7:0]  d;
		int          fall;
		run = start;
		start_load(`VIC_IDX_PRG, 8'h00);
		host_send(25'd0, start[7:0], 1'b0, 16'h0);
		host_send(25'd1, start[15:8], 1'b0, 16'h0);
		for (int i = 0; i < n; i++) begin
			d = 8'($urandom);
			host_send(25'(i + 2), d, run < `VIC_PRG_LIMIT, run);
			if (run < `VIC_PRG_LIMIT)
				run = run + 16'd1;
		end
		end_load();
		fall = cycles;
		// End address into each pointer pair, low byte first
		for (int i = 0; i < 8; i++)
			expect_wr(fall + 2 + 2 * i, PTR_ADDR[i], (i % 2 == 1) ? run[15:8] : run[7:0]);
		repeat (20) step();
		check(exp_q.size() == 0, "program load writes missing");
	endtask

	////////////////////////////////
	// Models and monitors
	////////////////////////////////

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout: the run did not complete within %0d cycles", TIMEOUT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Ready after 1 to 4 cycles, random FIFO full
	always @(posedge clk_sys) begin
		#2;
		tmem_ready = 1'b0;
		if (mem_delay > 0) begin
			mem_delay--;
			if (mem_delay == 0) begin
				tmem_ready = 1'b1;
				tmem_dout = rd_data;
			end
		end
		fifo_full = full_hold || ($urandom % 3 == 0);
	end

	always @(negedge clk_sys) begin
		if (!reset && mem_wr.wr) begin
			check(exp_q.size() != 0, $sformatf("memory write to %h not expected", mem_wr.addr));
			if (exp_q.size() != 0) begin
				got = exp_q.pop_front();
				check(got.cyc == cycles && got.addr == mem_wr.addr && got.data == mem_wr.data,
					$sformatf("write %h=%h at cycle %0d, expected %h=%h at %0d", mem_wr.addr,
					mem_wr.data, cycles, got.addr, got.data, got.cyc));
			end
		end
		if (fifo_wr) begin
			check(fifo_cnt < TAP_LEN + 2, "FIFO write past the end of the tape");
			check(fifo_data == (fifo_cnt < TAP_LEN ? tape_ref[fifo_cnt] : fill_byte(fifo_cnt)),
				$sformatf("FIFO byte %0d is %h", fifo_cnt, fifo_data));
			fifo_cnt++;
			reads_open--;
		end
		if (tmem_rd) begin
			check(reads_open == 0, "second tape read issued before the first finished");
			reads_open++;
			rd_data = tape_mem[tmem_addr[7:0]];
			mem_delay = 1 + int'($urandom % 4);
		end
		if (tmem_wr) begin
			tape_mem[tmem_addr[7:0]] = tmem_din;
			mem_delay = 1 + int'($urandom % 4);
		end
		if (tape_autoplay) begin
			autoplay_cnt++;
			autoplay_cyc = cycles;
		end
	end

	a_rd_room: assert property (@(posedge clk_sys) disable iff (reset)
		tmem_rd |-> !$past(fifo_full))
		else begin
			errors++;
			$display("error %0t: tape read started while the FIFO was full", $time);
		end

	a_tape_wr: assert property (@(posedge clk_sys) disable iff (reset)
		(host.wr && host.download && host.index == `VIC_IDX_TAP) |=> (tmem_wr && host_wait))
		else begin
			errors++;
			$display("error %0t: tape write or wait missing after host byte", $time);
		end

	a_host_hold: assert property (@(posedge clk_sys) disable iff (reset) host_wait |-> !host.wr)
		else begin
			errors++;
			$display("error %0t: host wrote while wait was high", $time);
		end

	////////////////////////////////
	// Test sequence
	////////////////////////////////

	initial begin
		logic [7:0] d;
		int         fall;
		void'($urandom(32'he62a_5815));
		reset = 1'b1;
		host = '0;
		exp_cfg = 5'b10100;
		tape_unload = 1'b0;
		autoplay_en = 1'b0;
		tmem_dout = 8'h00;
		tmem_ready = 1'b0;
		fifo_full = 1'b0;
		for (int i = 0; i < 256; i++)
			tape_mem[i] = fill_byte(i);
		repeat (5) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		check(!mem_wr.wr && !tmem_wr && !tmem_rd && !fifo_wr && !host_wait && !tape_autoplay,
			"strobes not low after reset");
		check(ram_ext == ram_vec(exp_cfg) && ram_ext_ro == 5'd0, "expansion map wrong after reset");

		// Every switch setting, no cartridge seen yet
		for (int c = 0; c < 32; c++) begin
			exp_cfg = 5'(c);
			step();
			check(ram_ext == ram_vec(exp_cfg) && ram_ext_ro == 5'd0,
				$sformatf("ram_ext %b for switches %b", ram_ext, exp_cfg));
		end

		load_prg(16'h1001, 8);
		load_prg(16'h9FFC, 8);

		// Kernal, only the 4000..7FFF window lands
		start_load(`VIC_IDX_ROM, 8'h00);
		for (int i = 0; i < 8; i++) begin
			d = 8'($urandom);
			host_send(ROM_OFS[i], d, ROM_OFS[i] >= `VIC_ROM_LO && ROM_OFS[i] < `VIC_ROM_HI,
				ROM_OFS[i][15:0] + `VIC_ROM_OFFSET);
		end
		end_load();
		repeat (4) step();
		check(exp_q.size() == 0, "kernal writes missing");

		exp_cfg = 5'b00100;
		start_load(`VIC_IDX_CRT, 8'h00);
		host_send(25'd0, 8'h00, 1'b0, 16'h0);
		host_send(25'd1, 8'hA0, 1'b0, 16'h0);
		for (int i = 0; i < 4; i++)
			host_send(25'(i + 2), 8'($urandom), 1'b1, 16'hA000 + 16'(i));
		end_load();
		repeat (3) step();
		check(exp_q.size() == 0 && ram_ext == (ram_vec(exp_cfg) | 5'b10000) &&
			ram_ext_ro == 5'b10000, "cartridge at A000 did not set block bit 4");

		start_load(`VIC_IDX_CT, "6");
		for (int i = 0; i < 4; i++)
			host_send(25'(i), 8'($urandom), 1'b1, 16'h6000 + 16'(i));
		end_load();
		repeat (3) step();
		check(exp_q.size() == 0 && ram_ext == (ram_vec(exp_cfg) | 5'b11000) &&
			ram_ext_ro == 5'b11000, "headerless cartridge did not start at 6000");
		exp_cfg.cart_wr = 1'b1;
		step();
		check(ram_ext_ro == 5'd0, "writable cartridge still marked read-only");
		exp_cfg.cart_wr = 1'b0;

		// Tape image, then playback into the FIFO
		autoplay_en = 1'b1;
		for (int i = 0; i < TAP_LEN; i++)
			tape_ref[i] = 8'($urandom);
		// Version bits differ from the reset value
		if (tape_ref[`VIC_TAP_VER_OFS][1:0] == 2'd0)
			tape_ref[`VIC_TAP_VER_OFS][1:0] = 2'd1;
		start_load(`VIC_IDX_TAP, 8'h00);
		for (int i = 0; i < TAP_LEN; i++)
			tape_send(i, tape_ref[i]);
		host.addr = 25'(TAP_LEN);
		end_load();
		fall = cycles;
		while (tape_loaded || fifo_cnt < TAP_LEN + 2)
			step();
		check(autoplay_cnt == 1 && autoplay_cyc == fall + 1, "autoplay did not pulse once");
		check(tape_version == tape_ref[`VIC_TAP_VER_OFS][1:0], "tape version differs from byte 0C");
		for (int i = 0; i < TAP_LEN; i++)
			check(tape_mem[i] == tape_ref[i], $sformatf("tape byte %0d not stored", i));

		full_hold = 1'b1;
		autoplay_en = 1'b0;
		start_load(`VIC_IDX_TAP, 8'h00);
		for (int i = 0; i < 4; i++)
			tape_send(i, 8'($urandom));
		host.addr = 25'd4;
		end_load();
		repeat (4) step();
		check(tape_loaded, "second tape not marked loaded");
		tape_unload = 1'b1;
		step();
		tape_unload = 1'b0;
		check(!tape_loaded, "tape unload did not clear the loaded flag");
		full_hold = 1'b0;
		repeat (8) step();
		check(fifo_cnt == TAP_LEN + 2 && autoplay_cnt == 1, "FIFO or autoplay activity after unload");
		check(exp_q.size() == 0, "expected memory writes never seen");

		$display("Loader run finished with %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: rtl/vic_loader_top.sv
//////////////////////////////
// Loader top level
// Image loader and tape buffer on the shared
// host download bus
//////////////////////////////

`timescale 1ns/1ps

`include "vic_load_cfg.svh"

module vic_loader_top import vic_load_pkg::*; (
	input  logic                    clk_sys_i,
	input  logic                    reset_i,
	input  host_xfer_t              host_i,
	input  exp_cfg_t                exp_cfg_i,
	input  logic                    tape_unload_i,
	input  logic                    tape_autoplay_en_i,
	output logic                    host_wait_o,
	output mem_wr_t                 mem_wr_o,
	output logic [4:0]              ram_ext_o,
	output logic [4:0]              ram_ext_ro_o,
	// Tape image memory
	output logic [`VIC_HOST_AW-1:0] tmem_addr_o,
	output logic [7:0]              tmem_din_o,
	output logic                    tmem_wr_o,
	output logic                    tmem_rd_o,
	input  logic [7:0]              tmem_dout_i,
	input  logic                    tmem_ready_i,
	// Player FIFO
	output logic [7:0]              fifo_data_o,
	output logic                    fifo_wr_o,
	input  logic                    fifo_full_i,
	output logic [1:0]              tape_version_o,
	output logic                    tape_loaded_o,
	output logic                    tape_autoplay_o
);

	image_loader image_loader_inst (
		.clk_sys_i    (clk_sys_i),
		.reset_i      (reset_i),
		.host_i       (host_i),
		.exp_cfg_i    (exp_cfg_i),
		.mem_wr_o     (mem_wr_o),
		.ram_ext_o    (ram_ext_o),
		.ram_ext_ro_o (ram_ext_ro_o)
	);

	tape_buffer tape_buffer_inst (
		.clk_sys_i          (clk_sys_i),
		.reset_i            (reset_i),
		.host_i             (host_i),
		.tape_unload_i      (tape_unload_i),
		.tape_autoplay_en_i (tape_autoplay_en_i),
		.tmem_dout_i        (tmem_dout_i),
		.tmem_ready_i       (tmem_ready_i),
		.fifo_full_i        (fifo_full_i),
		.host_wait_o        (host_wait_o),
		.tmem_addr_o        (tmem_addr_o),
		.tmem_din_o         (tmem_din_o),
		.tmem_wr_o          (tmem_wr_o),
		.tmem_rd_o          (tmem_rd_o),
		.fifo_data_o        (fifo_data_o),
		.fifo_wr_o          (fifo_wr_o),
		.tape_version_o     (tape_version_o),
		.tape_loaded_o      (tape_loaded_o),
		.tape_autoplay_o    (tape_autoplay_o)
	);

endmodule

// File: rtl/tape_buffer.sv
//////////////////////////////
// Tape buffer
// Stores a tape image in external memory while
// stalling the host, then feeds the stored bytes
// to the player FIFO
//////////////////////////////

`timescale 1ns/1ps

`include "vic_load_cfg.svh"

module tape_buffer import vic_load_pkg::*; (
	input  logic                    clk_sys_i,
	input  logic                    reset_i,
	input  host_xfer_t              host_i,
	input  logic                    tape_unload_i,
	input  logic                    tape_autoplay_en_i,
	input  logic [7:0]              tmem_dout_i,
	input  logic                    tmem_ready_i,
	input  logic                    fifo_full_i,
	output logic                    host_wait_o,
	output logic [`VIC_HOST_AW-1:0] tmem_addr_o,
	output logic [7:0]              tmem_din_o,
	output logic                    tmem_wr_o,
	output logic                    tmem_rd_o,
	output logic [7:0]              fifo_data_o,
	output logic                    fifo_wr_o,
	output logic [1:0]              tape_version_o,
	output logic                    tape_loaded_o,
	output logic                    tape_autoplay_o
);

	logic                    tap_dl;
	logic                    tap_dl_old;
	logic                    tap_restart;
	logic [`VIC_HOST_AW-1:0] play_addr;
	logic [`VIC_HOST_AW-1:0] end_addr;
	tape_fetch_e             fetch_state;

	assign tap_dl = host_i.download && decode_kind(host_i.index) == LOAD_TAP;
	assign tap_restart = reset_i | tap_dl | tape_unload_i;
	assign tape_loaded_o = play_addr < end_addr;
	assign tmem_addr_o = tap_dl ? host_i.addr : play_addr;

	////////////////////////////////
	// Host to tape memory
	////////////////////////////////

	always_ff @(posedge clk_sys_i) begin
		if (reset_i) begin
			host_wait_o <= 1'b0;
			tmem_wr_o <= 1'b0;
			tape_version_o <= 2'd0;
		end else begin
			tmem_wr_o <= 1'b0;
			if (host_i.wr && tap_dl) begin
				host_wait_o <= 1'b1;
				tmem_wr_o <= 1'b1;
				if (host_i.addr == `VIC_TAP_VER_OFS)
					tape_version_o <= host_i.data[1:0];
			end else if (!tmem_wr_o && host_wait_o && tmem_ready_i) begin
				// Write acknowledged, let the host send the next byte
				host_wait_o <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys_i) begin
		if (host_i.wr && tap_dl)
			tmem_din_o <= host_i.data;
	end

	////////////////////////////////
	// Playback fetch
	////////////////////////////////

	always_ff @(posedge clk_sys_i) begin
		if (tap_restart) begin
			// Player checks its FIFO early, so a couple of pad bytes follow the image
			end_addr <= tap_dl ? host_i.addr + `VIC_TAP_END_PAD : '0;
			play_addr <= '0;
			tmem_rd_o <= 1'b0;
			fifo_wr_o <= 1'b0;
			fetch_state <= FETCH_IDLE;
		end else begin
			tmem_rd_o <= 1'b0;
			fifo_wr_o <= 1'b0;
			if (!tmem_rd_o && !fifo_wr_o) begin
				case (fetch_state)
					FETCH_WAIT: begin
						if (tmem_ready_i) begin
							fifo_data_o <= tmem_dout_i;
							fifo_wr_o <= 1'b1;
							play_addr <= play_addr + 1'b1;
							fetch_state <= FETCH_IDLE;
						end
					end
					default: begin
						// Full flag is only checked here, before the read goes out
						if (!fifo_full_i && tape_loaded_o) begin
							tmem_rd_o <= 1'b1;
							fetch_state <= FETCH_WAIT;
						end
					end
				endcase
			end
		end
	end

	// One play request right after a tape arrives
	always_ff @(posedge clk_sys_i) begin
		if (reset_i) begin
			tap_dl_old <= 1'b0;
			tape_autoplay_o <= 1'b0;
		end else begin
			tap_dl_old <= tap_dl;
			tape_autoplay_o <= tap_dl_old & ~tap_dl & tape_autoplay_en_i;
		end
	end

endmodule

// File: rtl/image_loader.sv
//////////////////////////////
// Image loader
// Turns program, cartridge and kernal downloads into
// machine memory writes, patches the BASIC pointers
// after a program load and builds the expansion map
//////////////////////////////

`timescale 1ns/1ps

`include "vic_load_cfg.svh"

module image_loader import vic_load_pkg::*; (
	input  logic       clk_sys_i,
	input  logic       reset_i,
	input  host_xfer_t host_i,
	input  exp_cfg_t   exp_cfg_i,
	output mem_wr_t    mem_wr_o,
	output logic [4:0] ram_ext_o,
	output logic [4:0] ram_ext_ro_o
);

	load_kind_e kind;
	logic       dl_old;
	logic       dl_rise;
	logic       dl_fall;
	logic [15:0] run_addr;
	logic [3:0] ptr_cnt;
	logic [15:0] ptr_addr;
	logic [4:0] cart_blk;
	mem_wr_t    mem_wr_q;
	logic [7:0] ext_char;
	logic       ct_valid;
	logic [15:0] ct_start;
	logic [2:0] ext2_vec;
	logic [4:0] ram_base;

	assign kind = decode_kind(host_i.index);
	assign dl_rise = host_i.download & ~dl_old;
	assign dl_fall = dl_old & ~host_i.download;
	assign ext_char = host_i.file_ext[7:0];
	assign mem_wr_o = mem_wr_q;

	// Headerless cartridge start address from the extension digit
	always_comb begin
		ct_valid = 1'b1;
		ct_start = {ext_char[3:0], 12'h000};
		if (ext_char >= "A" && ext_char <= "B") begin
			ct_start = {ext_char[3:0] + 4'd9, 12'h000};
		end else if (ext_char < "2" || ext_char > "9") begin
			ct_valid = 1'b0;
		end
	end

	// Pointer order is 2D..32 then AE/AF, low byte on even slots
	always_comb begin
		case (ptr_cnt[3:1])
			3'd0: ptr_addr = `VIC_PTR_ADDR_0;
			3'd1: ptr_addr = `VIC_PTR_ADDR_1;
			3'd2: ptr_addr = `VIC_PTR_ADDR_2;
			3'd3: ptr_addr = `VIC_PTR_ADDR_3;
			3'd4: ptr_addr = `VIC_PTR_ADDR_4;
			3'd5: ptr_addr = `VIC_PTR_ADDR_5;
			3'd6: ptr_addr = `VIC_PTR_ADDR_6;
			default: ptr_addr = `VIC_PTR_ADDR_7;
		endcase
	end

	////////////////////////////////
	// Download to memory writes
	////////////////////////////////

	always_ff @(posedge clk_sys_i) begin
		if (reset_i) begin
			dl_old <= 1'b0;
			ptr_cnt <= 4'd0;
			cart_blk <= 5'd0;
			mem_wr_q.wr <= 1'b0;
		end else begin
			dl_old <= host_i.download;
			mem_wr_q.wr <= 1'b0;
			if (ptr_cnt != 4'd0)
				ptr_cnt <= ptr_cnt + 4'd1;

			// Program file, two byte load address header
			if (host_i.download && kind == LOAD_PRG) begin
				ptr_cnt <= 4'd0;
				if (host_i.wr) begin
					if (host_i.addr == '0) begin
						run_addr[7:0] <= host_i.data;
					end else if (host_i.addr == 25'd1) begin
						run_addr[15:8] <= host_i.data;
					end else if (run_addr < `VIC_PRG_LIMIT) begin
						mem_wr_q.addr <= run_addr;
						mem_wr_q.data <= host_i.data;
						mem_wr_q.wr <= 1'b1;
						run_addr <= run_addr + 16'd1;
					end
				end
			end

			// End address goes to the BASIC pointers once the file is in
			if (dl_fall && kind == LOAD_PRG)
				ptr_cnt <= 4'd1;
			if (ptr_cnt[0]) begin
				mem_wr_q.addr <= ptr_addr;
				mem_wr_q.data <= ptr_cnt[1] ? run_addr[15:8] : run_addr[7:0];
				mem_wr_q.wr <= 1'b1;
			end

			// Kernal image, only the upper 16K of the file is used
			if (host_i.download && kind == LOAD_ROM) begin
				ptr_cnt <= 4'd0;
				if (host_i.wr && host_i.addr >= `VIC_ROM_LO && host_i.addr < `VIC_ROM_HI) begin
					mem_wr_q.addr <= host_i.addr[15:0] + `VIC_ROM_OFFSET;
					mem_wr_q.data <= host_i.data;
					mem_wr_q.wr <= 1'b1;
				end
			end

			// Cartridges, headed or with address from the extension
			if (host_i.download && (kind == LOAD_CRT || kind == LOAD_CT) && host_i.wr) begin
				if (host_i.addr == '0 && kind == LOAD_CRT) begin
					run_addr[7:0] <= host_i.data;
				end else if (host_i.addr == 25'd1 && kind == LOAD_CRT) begin
					run_addr[15:8] <= host_i.data;
				end else if (run_addr < `VIC_CART_LIMIT) begin
					case (run_addr[15:13])
						3'b000: cart_blk[0] <= 1'b1;
						3'b001: cart_blk[1] <= 1'b1;
						3'b010: cart_blk[2] <= 1'b1;
						3'b011: cart_blk[3] <= 1'b1;
						3'b101: cart_blk[4] <= 1'b1;
						default: ;
					endcase
					mem_wr_q.addr <= run_addr;
					mem_wr_q.data <= host_i.data;
					mem_wr_q.wr <= 1'b1;
					run_addr <= run_addr + 16'd1;
				end
			end

			if (dl_rise && kind == LOAD_CT && ct_valid)
				run_addr <= ct_start;
		end
	end

	////////////////////////////////
	// Expansion map
	////////////////////////////////

	always_comb begin
		case (exp_cfg_i.ext2_sel)
			2'd0: ext2_vec = 3'b000;
			2'd1: ext2_vec = 3'b001;
			2'd2: ext2_vec = 3'b011;
			default: ext2_vec = 3'b111;
		endcase
		ram_base = {exp_cfg_i.ext3_en, ext2_vec, exp_cfg_i.ext1_en};
	end

	always_ff @(posedge clk_sys_i) begin
		if (reset_i) begin
			ram_ext_o <= ram_base;
			ram_ext_ro_o <= 5'd0;
		end else begin
			ram_ext_o <= ram_base | cart_blk;
			// Writable cartridge RAM drops the read-only marking
			ram_ext_ro_o <= cart_blk & ~{5{exp_cfg_i.cart_wr}};
		end
	end

endmodule

// File: rtl/vic_load_pkg.sv
//////////////////////////////
// Loader types
// Load kinds, tape fetch states, host and memory
// bus structs, index decoding
//////////////////////////////

`include "vic_load_cfg.svh"

package vic_load_pkg;

	typedef enum logic [2:0] {
		LOAD_NONE,
		LOAD_PRG,
		LOAD_CRT,
		LOAD_CT,
		LOAD_TAP,
		LOAD_ROM
	} load_kind_e;

	typedef enum logic {
		FETCH_IDLE,
		FETCH_WAIT
	} tape_fetch_e;

	// Host download bus, as delivered by the IO controller
	typedef struct packed {
		logic                    download;
		logic [7:0]              index;
		logic                    wr;
		logic [`VIC_HOST_AW-1:0] addr;
		logic [7:0]              data;
		logic [31:0]             file_ext;
	} host_xfer_t;

	// Byte write into machine memory
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        wr;
	} mem_wr_t;

	// RAM expansion switches
	typedef struct packed {
		logic       ext1_en;
		logic [1:0] ext2_sel;
		logic       ext3_en;
		logic       cart_wr;
	} exp_cfg_t;

	function automatic load_kind_e decode_kind(input logic [7:0] idx);
		case (idx)
			`VIC_IDX_PRG: decode_kind = LOAD_PRG;
			`VIC_IDX_CRT: decode_kind = LOAD_CRT;
			`VIC_IDX_CT: decode_kind = LOAD_CT;
			`VIC_IDX_TAP: decode_kind = LOAD_TAP;
			`VIC_IDX_ROM: decode_kind = LOAD_ROM;
			default: decode_kind = LOAD_NONE;
		endcase
	endfunction

endpackage

// File: rtl/vic_load_cfg.svh
//////////////////////////////
// Loader configuration
// Host index codes, memory map limits, BASIC pointer
// addresses and tape constants
//////////////////////////////

`ifndef VIC_LOAD_CFG_SVH
`define VIC_LOAD_CFG_SVH

// Host download index codes
`define VIC_IDX_PRG 8'h01
`define VIC_IDX_CRT 8'h41
`define VIC_IDX_CT 8'h81
`define VIC_IDX_TAP 8'hC1
`define VIC_IDX_ROM 8'h06

// Host and tape address width
`define VIC_HOST_AW 25

// Load limits in machine memory
`define VIC_PRG_LIMIT 16'hA000
`define VIC_CART_LIMIT 16'hC000

// Kernal window in the ROM file and its placement
`define VIC_ROM_LO 25'h0004000
`define VIC_ROM_HI 25'h0008000
`define VIC_ROM_OFFSET 16'h8000

// BASIC pointers patched after a program load, in write order
`define VIC_PTR_ADDR_0 16'h002D
`define VIC_PTR_ADDR_1 16'h002E
`define VIC_PTR_ADDR_2 16'h002F
`define VIC_PTR_ADDR_3 16'h0030
`define VIC_PTR_ADDR_4 16'h0031
`define VIC_PTR_ADDR_5 16'h0032
`define VIC_PTR_ADDR_6 16'h00AE
`define VIC_PTR_ADDR_7 16'h00AF

// Tape image layout
`define VIC_TAP_VER_OFS 25'h000000C
`define VIC_TAP_END_PAD 25'd2

`endif
